/* pipe_core.f */
+incdir+verification
hdl/core_pkg.sv
hdl/hazard_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/pipe_core.sv
verification/pipe_core_tb.sv

/* Makefile */
TOP       ?= pipe_core_tb
FILELIST  ?= pipe_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verification/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Test OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/pipe_core_model.svh */
`ifndef PIPE_CORE_MODEL_SVH
`define PIPE_CORE_MODEL_SVH

localparam int PROG_LEN = 21;

logic [31:0] prog [PROG_LEN];
logic [4:0]  exp_rd [$];
logic [31:0] exp_data [$];

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, 3'b010 & {3{op == 7'b0000011}}, rd, op};  // LW uses funct3 010
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
endfunction

// Initial data memory contents, mixes every address bit
function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]} ^ 32'h0f0f_3c3c;
endfunction

task automatic load_program();
    prog[0]  = enc_i(12'd5, 5'd0, 5'd1, 7'b0010011);    // addi x1,x0,5
    prog[1]  = enc_i(-12'sd3, 5'd0, 5'd2, 7'b0010011);  // addi x2,x0,-3
    prog[2]  = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);  // add x3,x1,x2
    prog[3]  = enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4);  // sub x4,x1,x2
    prog[4]  = enc_r(7'h00, 5'd1, 5'd4, 3'b110, 5'd6);  // or x6,x4,x1
    prog[5]  = enc_r(7'h00, 5'd1, 5'd6, 3'b111, 5'd5);  // and x5,x6,x1
    prog[6]  = enc_i(12'd7, 5'd0, 5'd0, 7'b0010011);    // addi x0,x0,7
    prog[7]  = enc_s(12'd16, 5'd6, 5'd0);               // sw x6,16(x0)
    prog[8]  = enc_i(12'd16, 5'd0, 5'd7, 7'b0000011);   // lw x7,16(x0)
    prog[9]  = enc_r(7'h00, 5'd1, 5'd7, 3'b000, 5'd8);  // add x8,x7,x1
    prog[10] = enc_i(12'h100, 5'd0, 5'd9, 7'b0010011);  // addi x9,x0,0x100
    prog[11] = enc_s(12'd4, 5'd8, 5'd9);                // sw x8,4(x9)
    prog[12] = enc_i(12'd4, 5'd9, 5'd10, 7'b0000011);   // lw x10,4(x9)
    prog[13] = enc_b(13'd12, 5'd8, 5'd10);              // beq taken to 16
    prog[14] = enc_i(12'd1, 5'd0, 5'd11, 7'b0010011);   // Wrong path
    prog[15] = enc_i(12'd2, 5'd0, 5'd12, 7'b0010011);   // Wrong path
    prog[16] = enc_b(13'd8, 5'd2, 5'd1);                // beq not taken
    prog[17] = enc_i(-12'sd20, 5'd10, 5'd13, 7'b0010011);
    prog[18] = enc_i(12'd32, 5'd0, 5'd14, 7'b0000011);  // lw from untouched word
    prog[19] = enc_r(7'h00, 5'd13, 5'd14, 3'b110, 5'd15);
    prog[20] = enc_b(13'd0, 5'd0, 5'd0);                // Self-loop
endtask

// Runs the program in order and records each register write
task automatic run_model();
    logic [31:0] x [32];
    logic [31:0] dm [logic [31:0]];
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] res;
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] imm_i;
    logic        wr;
    int          steps;
    for (int i = 0; i < 32; i++) x[i] = 32'd0;
    pc = 32'd0;
    steps = 0;
    while (steps < 200 && prog[int'(pc >> 2)] != enc_b(13'd0, 5'd0, 5'd0)) begin
        w = prog[int'(pc >> 2)];
        v1 = x[w[19:15]];
        v2 = x[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        wr = 1'b1;
        res = 32'd0;
        case (w[6:0])
            7'b0110011: begin
                if (w[14:12] == 3'b111) res = v1 & v2;
                else if (w[14:12] == 3'b110) res = v1 | v2;
                else res = w[30] ? v1 - v2 : v1 + v2;
            end
            7'b0010011: res = v1 + imm_i;
            7'b0000011: begin
                a = v1 + imm_i;
                res = dm.exists(a) ? dm[a] : fill_word(a);
            end
            7'b0100011: begin
                dm[v1 + {{20{w[31]}}, w[31:25], w[11:7]}] = v2;
                wr = 1'b0;
            end
            default: wr = 1'b0;  // BEQ
        endcase
        if (w[6:0] == 7'b1100011 && v1 == v2) begin
            pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end else begin
            pc = pc + 32'd4;
        end
        if (wr && w[11:7] != 5'd0) begin
            x[w[11:7]] = res;
            exp_rd.push_back(w[11:7]);
            exp_data.push_back(res);
        end
        steps++;
    end
endtask

`endif

/* verification/pipe_core_tb.sv */
`timescale 1ns/1ps

module pipe_core_tb;

    `include "pipe_core_model.svh"

    localparam int WATCHDOG_CYCLES = PROG_LEN * (4 + 6) + 40;

    logic                clk;
    logic                rstN;
    logic [31:0]         imem_addr;
    logic [31:0]         imem_data;
    core_pkg::dmem_req_t dmem_req;
    logic [31:0]         dmem_rdata;
    logic                mem_ready;
    core_pkg::wb_t       retire;

    logic [31:0]         dmem [1024];
    logic [31:0]         lfsr;
    logic                mem_fetched;
    int                  exp_idx;

    pipe_core #(
        .PC_RESET(32'h0)
    ) DUT (
        .clk(clk), .rstN(rstN), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_req(dmem_req), .dmem_rdata(dmem_rdata), .mem_ready(mem_ready),
        .retire(retire)
    );

    // Instruction memory answers in the same cycle
    assign imem_data = (imem_addr[31:2] < 30'(PROG_LEN)) ? prog[imem_addr[6:2]] :
                       core_pkg::NOP_INSTR;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic take_bit();
        logic b;
        b = lfsr[0];
        lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ************************************************
    // Data memory with level ready protocol
    // ************************************************
    initial begin
        core_pkg::dmem_req_t req_s;
        int                  mstate;
        int                  lat;
        mstate = 0;
        lat = 0;
        forever begin
            @(posedge clk);
            req_s = dmem_req;
            #1;
            case (mstate)
                0: if (rstN && (req_s.read || req_s.write)) begin
                    mem_ready = 1'b0;
                    lat = 1 + int'(take_bit()) + 2 * int'(take_bit());
                    mstate = 1;
                end
                1: if (lat > 1) begin
                    lat--;
                end else begin
                    if (req_s.write) dmem[req_s.addr[11:2]] = req_s.wdata;
                    dmem_rdata = dmem[req_s.addr[11:2]];
                    mem_ready = 1'b1;
                    mstate = 2;
                end
                default: mstate = 0;  // Completing request still visible
            endcase
        end
    end

    always @(posedge clk) begin
        if (imem_data[6:0] == 7'b0000011 || imem_data[6:0] == 7'b0100011) begin
            mem_fetched <= 1'b1;
        end
    end

    // ************************************************
    // Checks
    // ************************************************
    assert property (@(posedge clk) disable iff (!rstN)
        ((dmem_req.read || dmem_req.write) && !mem_ready) |=>
        ($stable(dmem_req.addr) && $stable(dmem_req.wdata)))
        else fail_run("dmem_req address or write data changed while mem_ready was low");

    assert property (@(posedge clk) disable iff (!rstN)
        !mem_fetched |-> !(dmem_req.read || dmem_req.write))
        else fail_run("memory request issued before any load or store was fetched");

    assert property (@(posedge clk) !rstN |=> !retire.en)
        else fail_run("retire.en high right after reset");

    always @(negedge clk) begin
        if (rstN && retire.en) begin
            assert (exp_idx < exp_rd.size())
                else fail_run("retire beyond the end of the expected sequence");
            assert (retire.rd != 5'd0) else fail_run("write to x0 retired");
            assert (retire.rd == exp_rd[exp_idx])
                else fail_run($sformatf("ERR %0t retire.rd expected %0d actual %0d",
                                        $time, exp_rd[exp_idx], retire.rd));
            assert (retire.data == exp_data[exp_idx])
                else fail_run($sformatf("ERR %0t retire.data expected %h actual %h",
                                        $time, exp_data[exp_idx], retire.data));
            exp_idx++;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("Watchdog expired with %0d of %0d retires seen", exp_idx, exp_rd.size());
        $display("Test FAILED");
        $fatal(1);
    end

    initial begin
        rstN = 1'b0;
        mem_ready = 1'b1;
        dmem_rdata = 32'd0;
        lfsr = 32'h38f0_fd4b;
        mem_fetched = 1'b0;
        exp_idx = 0;
        for (int i = 0; i < 1024; i++) dmem[i] = fill_word(32'(i) << 2);
        load_program();
        run_model();
        repeat (3) @(posedge clk);
        #1 rstN = 1'b1;
        wait (exp_idx == exp_rd.size());
        repeat (20) @(posedge clk);  // Extra retires in this window fail the checker
        $display("Test OK");
        $finish;
    end

endmodule : pipe_core_tb

/* hdl/pipe_core.sv */
`timescale 1ns/1ps

module pipe_core #(
    parameter logic [31:0] PC_RESET = 32'h0
) (
    input  logic                clk,
    input  logic                rstN,
    output logic [31:0]         imem_addr,
    input  logic [31:0]         imem_data,
    output core_pkg::dmem_req_t dmem_req,
    input  logic [31:0]         dmem_rdata,
    input  logic                mem_ready,
    output core_pkg::wb_t       retire
);

    core_pkg::hazard_ctrl_t hazard_ctrl;
    core_pkg::id_ex_t       decoded;
    core_pkg::id_ex_t       id_ex;
    core_pkg::wb_t          wb;
    logic [4:0]             if_id_rs1;
    logic [4:0]             if_id_rs2;
    logic                   take_branch;
    logic [31:0]            branch_target;
    logic [31:0]            alu_result;
    logic                   mem_wait;
    logic                   mem_done;

    assign retire = wb;

    decode_stage #(
        .PC_RESET(PC_RESET)
    ) u_decode (
        .clk(clk), .rstN(rstN), .hazard_ctrl(hazard_ctrl), .branch_target(branch_target),
        .wb(wb), .imem_data(imem_data), .imem_addr(imem_addr),
        .if_id_rs1(if_id_rs1), .if_id_rs2(if_id_rs2), .decoded(decoded)
    );

    execute_stage u_execute (
        .clk(clk), .rstN(rstN), .hazard_ctrl(hazard_ctrl), .decoded(decoded),
        .id_ex(id_ex), .take_branch(take_branch), .branch_target(branch_target),
        .alu_result(alu_result), .dmem_req(dmem_req)
    );

    result_stage u_result (
        .clk(clk), .rstN(rstN), .id_ex(id_ex), .alu_result(alu_result),
        .dmem_rdata(dmem_rdata), .mem_wait(mem_wait), .mem_done(mem_done), .wb(wb)
    );

    hazard_unit u_hazard (
        .clk(clk), .rstN(rstN), .if_id_rs1(if_id_rs1), .if_id_rs2(if_id_rs2),
        .id_ex_rd(id_ex.rd), .id_ex_reg_write(id_ex.reg_write),
        .id_ex_mem_read(id_ex.mem_read), .id_ex_mem_write(id_ex.mem_write),
        .take_branch(take_branch), .mem_ready(mem_ready),
        .hazard_ctrl(hazard_ctrl), .mem_wait(mem_wait), .mem_done(mem_done)
    );

endmodule : pipe_core

/* hdl/result_stage.sv */
`timescale 1ns/1ps

module result_stage (
    input  logic             clk,
    input  logic             rstN,
    input  core_pkg::id_ex_t id_ex,
    input  logic [31:0]      alu_result,
    input  logic [31:0]      dmem_rdata,
    input  logic             mem_wait,
    input  logic             mem_done,
    output core_pkg::wb_t    wb
);

    logic        res_valid;
    logic        res_reg_write;
    logic [4:0]  res_rd;
    logic [31:0] res_data;

    // ************************************************
    // EX/result register
    // ************************************************
    always_ff @(posedge clk) begin
        if (!rstN) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= id_ex.valid && !mem_wait;  // Bubble while memory is busy
        end
    end

    always_ff @(posedge clk) begin
        res_reg_write <= id_ex.reg_write;
        res_rd        <= id_ex.rd;
        if (mem_done && id_ex.mem_read) begin
            res_data <= dmem_rdata;  // Only valid on the completing cycle
        end else begin
            res_data <= alu_result;
        end
    end

    // Writeback record, also the retire port
    assign wb.en   = res_valid && res_reg_write && (res_rd != 5'd0);
    assign wb.rd   = res_rd;
    assign wb.data = res_data;

endmodule : result_stage

/* hdl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                   clk,
    input  logic                   rstN,
    input  core_pkg::hazard_ctrl_t hazard_ctrl,
    input  core_pkg::id_ex_t       decoded,
    output core_pkg::id_ex_t       id_ex,
    output logic                   take_branch,
    output logic [31:0]            branch_target,
    output logic [31:0]            alu_result,
    output core_pkg::dmem_req_t    dmem_req
);

    logic [31:0] operand_b;

    // ************************************************
    // ID/EX register
    // ************************************************
    always_ff @(posedge clk) begin
        if (!rstN) begin
            id_ex <= '0;
        end else if (hazard_ctrl.id_ex_enable) begin
            if (hazard_ctrl.id_ex_bubble) begin
                id_ex <= '0;  // Empty slot, all flags low
            end else begin
                id_ex <= decoded;
            end
        end
    end

    // ************************************************
    // ALU and branch
    // ************************************************
    assign operand_b = id_ex.use_imm ? id_ex.imm : id_ex.rs2_val;

    always_comb begin
        case (id_ex.alu_op)
            core_pkg::alu_sub: alu_result = id_ex.rs1_val - operand_b;
            core_pkg::alu_and: alu_result = id_ex.rs1_val & operand_b;
            core_pkg::alu_or:  alu_result = id_ex.rs1_val | operand_b;
            default:           alu_result = id_ex.rs1_val + operand_b;  // ADD, ADDI, LW, SW
        endcase
    end

    assign take_branch   = id_ex.valid && id_ex.branch && (id_ex.rs1_val == id_ex.rs2_val);
    assign branch_target = id_ex.pc + id_ex.imm;

    // Held steady by the frozen ID/EX register
    always_comb begin
        dmem_req.read  = id_ex.valid && id_ex.mem_read;
        dmem_req.write = id_ex.valid && id_ex.mem_write;
        dmem_req.addr  = alu_result;
        dmem_req.wdata = id_ex.rs2_val;
    end

    assert property (@(posedge clk) disable iff (!rstN) !(dmem_req.read && dmem_req.write))
        else $error("read and write requested together");

endmodule : execute_stage

/* hdl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage #(
    parameter logic [31:0] PC_RESET = 32'h0
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  core_pkg::hazard_ctrl_t hazard_ctrl,
    input  logic [31:0]            branch_target,
    input  core_pkg::wb_t          wb,
    input  logic [31:0]            imem_data,
    output logic [31:0]            imem_addr,
    output logic [4:0]             if_id_rs1,
    output logic [4:0]             if_id_rs2,
    output core_pkg::id_ex_t       decoded
);

    logic [31:0]      pc;
    logic             if_id_valid;
    logic [31:0]      if_id_pc;
    core_pkg::instr_u if_id_instr;
    logic [31:0]      regs [32];
    logic [31:0]      rs1_val;
    logic [31:0]      rs2_val;
    logic [31:0]      imm_i;
    logic [31:0]      imm_s;
    logic [31:0]      imm_b;
    logic             uses_rs2;

    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc          <= PC_RESET;
            if_id_valid <= 1'b0;
        end else begin
            if (hazard_ctrl.pc_write) begin
                pc <= hazard_ctrl.if_id_flush ? branch_target : pc + 32'd4;
            end
            if (hazard_ctrl.if_id_flush) begin
                if_id_valid <= 1'b0;
            end else if (hazard_ctrl.if_id_write) begin
                if_id_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hazard_ctrl.if_id_flush) begin
            if_id_instr <= core_pkg::instr_u'(core_pkg::NOP_INSTR);
        end else if (hazard_ctrl.if_id_write) begin
            if_id_instr <= core_pkg::instr_u'(imem_data);
            if_id_pc    <= pc;
        end
    end

    // ************************************************
    // Register file, write-through on read
    // ************************************************
    always_ff @(posedge clk) begin
        if (wb.en && (wb.rd != 5'd0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs1_val = (if_id_instr.r.rs1 == 5'd0) ? 32'd0 :
                     (wb.en && (wb.rd == if_id_instr.r.rs1)) ? wb.data :
                     regs[if_id_instr.r.rs1];
    assign rs2_val = (if_id_instr.r.rs2 == 5'd0) ? 32'd0 :
                     (wb.en && (wb.rd == if_id_instr.r.rs2)) ? wb.data :
                     regs[if_id_instr.r.rs2];

    // Immediates from the two views of the word
    assign imm_i = {{20{if_id_instr.r.funct7[6]}}, if_id_instr.r.funct7, if_id_instr.r.rs2};
    assign imm_s = {{20{if_id_instr.s.imm_hi[6]}}, if_id_instr.s.imm_hi, if_id_instr.s.imm_lo};
    assign imm_b = {{19{if_id_instr.s.imm_hi[6]}}, if_id_instr.s.imm_hi[6],
                    if_id_instr.s.imm_lo[0], if_id_instr.s.imm_hi[5:0],
                    if_id_instr.s.imm_lo[4:1], 1'b0};

    assign if_id_rs1 = if_id_valid ? if_id_instr.r.rs1 : 5'd0;
    assign if_id_rs2 = uses_rs2 ? if_id_instr.r.rs2 : 5'd0;  // I-type has no rs2

    always_comb begin
        decoded         = '0;
        uses_rs2        = 1'b0;
        decoded.valid   = if_id_valid;
        decoded.pc      = if_id_pc;
        decoded.rs1_val = rs1_val;
        decoded.rs2_val = rs2_val;
        if (if_id_valid) begin
            case (if_id_instr.r.opcode)
                core_pkg::opc_op: begin
                    decoded.rd        = if_id_instr.r.rd;
                    decoded.reg_write = 1'b1;
                    uses_rs2          = 1'b1;
                    case (if_id_instr.r.funct3)
                        3'b111:  decoded.alu_op = core_pkg::alu_and;
                        3'b110:  decoded.alu_op = core_pkg::alu_or;
                        default: decoded.alu_op = if_id_instr.r.funct7[5] ?
                                                  core_pkg::alu_sub : core_pkg::alu_add;
                    endcase
                end
                core_pkg::opc_op_imm, core_pkg::opc_load: begin
                    decoded.rd        = if_id_instr.r.rd;
                    decoded.reg_write = 1'b1;
                    decoded.use_imm   = 1'b1;
                    decoded.imm       = imm_i;
                    decoded.mem_read  = (if_id_instr.r.opcode == core_pkg::opc_load);
                end
                core_pkg::opc_store: begin
                    decoded.use_imm   = 1'b1;
                    decoded.imm       = imm_s;
                    decoded.mem_write = 1'b1;
                    uses_rs2          = 1'b1;
                end
                core_pkg::opc_branch: begin
                    decoded.branch = 1'b1;
                    decoded.imm    = imm_b;
                    uses_rs2       = 1'b1;
                end
                default: ;  // Outside the subset, passes as a no-op
            endcase
        end
    end

    // Result stage never commits to x0
    assert property (@(posedge clk) disable iff (!rstN) wb.en |-> (wb.rd != 5'd0))
        else $error("writeback to x0");

endmodule : decode_stage

/* hdl/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [4:0]             if_id_rs1,
    input  logic [4:0]             if_id_rs2,
    input  logic [4:0]             id_ex_rd,
    input  logic                   id_ex_reg_write,
    input  logic                   id_ex_mem_read,
    input  logic                   id_ex_mem_write,
    input  logic                   take_branch,
    input  logic                   mem_ready,
    output core_pkg::hazard_ctrl_t hazard_ctrl,
    output logic                   mem_wait,
    output logic                   mem_done
);

    typedef enum logic [2:0] {
        idle             = 3'd0,
        before_read_mem  = 3'd1,
        read_mem         = 3'd2,
        before_write_mem = 3'd3,
        write_mem        = 3'd4
    } state_t;

    state_t state;
    state_t next_state;
    logic   raw_hazard;

    // ************************************************
    // Memory wait FSM
    // ************************************************
    assign mem_done = ((state == read_mem) || (state == write_mem)) && mem_ready;
    assign mem_wait = ((state != idle) && !mem_done) ||
                      ((state == idle) && (id_ex_mem_read || id_ex_mem_write));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (id_ex_mem_read) begin
                    next_state = before_read_mem;
                end else if (id_ex_mem_write) begin
                    next_state = before_write_mem;
                end
            end
            before_read_mem:  if (!mem_ready) next_state = read_mem;    // Wait for the drop
            read_mem:         if (mem_ready) next_state = idle;         // Data valid now
            before_write_mem: if (!mem_ready) next_state = write_mem;
            write_mem:        if (mem_ready) next_state = idle;
            default:          next_state = idle;
        endcase
    end

    // ************************************************
    // Pipeline enables
    // ************************************************
    assign raw_hazard = id_ex_reg_write && (id_ex_rd != 5'd0) &&
                        ((id_ex_rd == if_id_rs1) || (id_ex_rd == if_id_rs2));

    always_comb begin
        hazard_ctrl = '{pc_write: 1'b1, if_id_write: 1'b1, if_id_flush: 1'b0,
                        id_ex_enable: 1'b1, id_ex_bubble: 1'b0};
        if (mem_wait) begin  // Freeze everything
            hazard_ctrl.pc_write     = 1'b0;
            hazard_ctrl.if_id_write  = 1'b0;
            hazard_ctrl.id_ex_enable = 1'b0;
        end else if (take_branch) begin  // Kill two wrong-path slots
            hazard_ctrl.if_id_flush  = 1'b1;
            hazard_ctrl.id_ex_bubble = 1'b1;
        end else if (raw_hazard) begin  // One cycle, write-through covers the rest
            hazard_ctrl.pc_write     = 1'b0;
            hazard_ctrl.if_id_write  = 1'b0;
            hazard_ctrl.id_ex_bubble = 1'b1;
        end
    end

    // ID/EX stays frozen on the access while the FSM is busy
    assert property (@(posedge clk) disable iff (!rstN)
        (state != idle) |-> (id_ex_mem_read || id_ex_mem_write))
        else $error("memory FSM busy without a load or store in ID/EX");

endmodule : hazard_unit

/* hdl/core_pkg.sv */
package core_pkg;

    // ************************************************
    // Encodings
    // ************************************************
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,  // ADD SUB AND OR
        opc_op_imm = 7'b0010011,  // ADDI
        opc_load   = 7'b0000011,  // LW
        opc_store  = 7'b0100011,  // SW
        opc_branch = 7'b1100011   // BEQ
    } opcode_e;

    typedef enum logic [1:0] {
        alu_add = 2'd0,
        alu_sub = 2'd1,
        alu_and = 2'd2,
        alu_or  = 2'd3
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    typedef union packed {
        r_fmt_t r;  // Also carries the I immediate
        s_fmt_t s;  // Also carries the B immediate
    } instr_u;

    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;  // ADDI x0,x0,0

    // ************************************************
    // Pipeline records
    // ************************************************
    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] imm;
        alu_op_e     alu_op;
        logic        use_imm;
        logic        mem_read;
        logic        mem_write;
        logic        branch;
        logic        reg_write;
        logic [31:0] pc;
    } id_ex_t;

    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic        en;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

    typedef struct packed {
        logic pc_write;
        logic if_id_write;
        logic if_id_flush;
        logic id_ex_enable;
        logic id_ex_bubble;
    } hazard_ctrl_t;

endpackage : core_pkg
